/* common/csr_cfg.svh */
// Configuration values of the machine-mode CSR unit
// Included by the package and by every RTL file that needs a constant

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

////////////////////
// Data path widths
////////////////////

// Data word of the RV32 core
`define CSR_XLEN 32

// Free-running cycle/time counter and instret input
`define CSR_CNT_W 64

////////////////////
// Constant CSRs
////////////////////

// mhartid, single hart
`define CSR_HART_ID 32'h0000_0000

// MXL=1 (32 bits) in [31:30], I extension in bit 8
`define CSR_MISA_VALUE 32'h4000_0100

////////////////////
// Reset and legal values
////////////////////

// Value loaded in every writable CSR on reset
`define CSR_RESET_WORD 32'h0000_0000

// Writable mstatus fields: MPP [12:11], MPIE [7], MIE [3]
`define CSR_MSTATUS_MASK 32'h0000_1888

// Interrupt enable and pending bit positions
`define CSR_MSTATUS_MIE_BIT 3
`define CSR_MEIP_BIT 11
`define CSR_MTIP_BIT 7
`define CSR_MSIP_BIT 3

// Flops per interrupt pin synchronizer, two or more
`define CSR_SYNC_DEPTH 2

`endif

/* common/csr_pkg.sv */
// Types shared by the CSR unit blocks and its testbench
// Operation codes, supported addresses and data word types

`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    // One CSR or register file word
    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // Integer register index, same width as zimm
    typedef logic [4:0] reg_idx_t;

    // Raw 12-bit CSR address from the instruction
    typedef logic [11:0] csr_addr_t;

    // Zicsr funct3 encodings
    typedef enum logic [2:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_e;

    // Supported CSR addresses
    typedef enum logic [11:0] {
        // Trap setup
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        // Trap handling
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        // Counters, low then high halves
        CSR_CYCLE    = 12'hC00,
        CSR_TIME     = 12'hC01,
        CSR_INSTRET  = 12'hC02,
        CSR_CYCLEH   = 12'hC80,
        CSR_TIMEH    = 12'hC81,
        CSR_INSTRETH = 12'hC82,
        // Machine information
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

endpackage

`default_nettype wire

/* design/access/csr_access_ctrl.sv */
// Decodes a Zicsr instruction, builds the CSR write and the new value,
// and registers the old value toward the register file

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_access_ctrl
    import csr_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    input  wire         valid,
    input  wire  [31:0] instbus,
    input  csr_word_t   rs1_val,
    input  csr_word_t   old_val,
    output reg_idx_t    rs1_addr,
    output csr_addr_t   csr_addr,
    output logic        csr_wr_en,
    output csr_word_t   csr_wdata,
    output logic        rd_wr_en,
    output reg_idx_t    rd_wr_addr,
    output csr_word_t   rd_wr_val
);

    // Instruction fields
    logic [2:0] funct3;
    reg_idx_t   rs1_idx;
    reg_idx_t   rd_idx;
    csr_op_e    op;

    // Operand selection
    logic       imm_form;
    logic       src_nonzero;
    csr_word_t  zimm_ext;
    csr_word_t  mask;

    ////////////////////
    // Field split
    ////////////////////

    assign funct3   = instbus[14:12];
    assign rs1_idx  = instbus[19:15];
    assign rd_idx   = instbus[11:7];
    assign csr_addr = instbus[31:20];
    assign op       = csr_op_e'(funct3);

    // rs1 query to the register file, answered in the same cycle
    assign rs1_addr = rs1_idx;

    // zimm sits in the rs1 field
    assign zimm_ext    = {{(`CSR_XLEN-5){1'b0}}, rs1_idx};
    assign imm_form    = funct3[2];
    assign src_nonzero = (rs1_idx != 5'd0);
    assign mask        = imm_form ? zimm_ext : rs1_val;

    ////////////////////
    // New value
    ////////////////////

    always_comb begin
        csr_wr_en = 1'b0;
        csr_wdata = old_val;
        case (op)
            // Plain write, even with x0 or zero immediate
            CSRRW, CSRRWI: begin
                csr_wr_en = valid;
                csr_wdata = mask;
            end
            // Set bits, no write for a zero source
            CSRRS, CSRRSI: begin
                csr_wr_en = valid && src_nonzero;
                csr_wdata = old_val | mask;
            end
            // Clear the bits set in the mask
            CSRRC, CSRRCI: begin
                csr_wr_en = valid && src_nonzero;
                csr_wdata = old_val & ~mask;
            end
            // Reserved funct3, read only
            default: begin
                csr_wr_en = 1'b0;
                csr_wdata = old_val;
            end
        endcase
    end

    ////////////////////
    // Write-back stage
    ////////////////////

    // One write-back per accepted instruction, rd=0 included
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_wr_en <= 1'b0;
        end else begin
            rd_wr_en <= valid;
        end
    end

    // Old value captured before the CSR update lands
    always_ff @(posedge aclk) begin
        if (valid) begin
            rd_wr_addr <= rd_idx;
            rd_wr_val  <= old_val;
        end
    end

endmodule

`default_nettype wire

/* design/access/csr_read_select.sv */
// Read side of the CSR file, holds the cycle/time counter and the
// constant CSRs, and returns the old value for the decoded address

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_read_select
    import csr_pkg::*;
(
    input  wire                     aclk,
    input  wire                     aresetn,
    input  csr_addr_t               csr_addr,
    input  wire  [`CSR_CNT_W-1:0]   instret,
    input  csr_word_t               mstatus,
    input  csr_word_t               mie,
    input  csr_word_t               mtvec,
    input  csr_word_t               mscratch,
    input  csr_word_t               mepc,
    input  csr_word_t               mcause,
    input  csr_word_t               mtval,
    input  csr_word_t               mip,
    output csr_word_t               old_val
);

    // Edges since reset release, shared by cycle and time
    logic [`CSR_CNT_W-1:0] cnt_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:           old_val = mstatus;
            CSR_MISA:              old_val = `CSR_MISA_VALUE;
            CSR_MIE:               old_val = mie;
            CSR_MTVEC:             old_val = mtvec;
            CSR_MSCRATCH:          old_val = mscratch;
            CSR_MEPC:              old_val = mepc;
            CSR_MCAUSE:            old_val = mcause;
            CSR_MTVAL:             old_val = mtval;
            CSR_MIP:               old_val = mip;
            // Low halves
            CSR_CYCLE, CSR_TIME:   old_val = cnt_q[`CSR_XLEN-1:0];
            CSR_INSTRET:           old_val = instret[`CSR_XLEN-1:0];
            // High halves
            CSR_CYCLEH, CSR_TIMEH: old_val = cnt_q[`CSR_CNT_W-1:`CSR_XLEN];
            CSR_INSTRETH:          old_val = instret[`CSR_CNT_W-1:`CSR_XLEN];
            CSR_MHARTID:           old_val = `CSR_HART_ID;
            // Unimplemented space reads as zero
            default:               old_val = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/regs/csr_machine_regs.sv */
// Writable trap-setup and trap-handling CSRs of machine mode
// Trap-entry writes from the control unit win over CSR instructions

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_machine_regs
    import csr_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    // Instruction write port
    input  wire         csr_wr_en,
    input  csr_addr_t   csr_addr,
    input  csr_word_t   csr_wdata,
    // Trap-entry writes
    input  wire         ctrl_mstatus_wr,
    input  csr_word_t   ctrl_mstatus,
    input  wire         ctrl_mepc_wr,
    input  csr_word_t   ctrl_mepc,
    input  wire         ctrl_mcause_wr,
    input  csr_word_t   ctrl_mcause,
    input  wire         ctrl_mtval_wr,
    input  csr_word_t   ctrl_mtval,
    // Current values
    output csr_word_t   mstatus,
    output csr_word_t   mie,
    output csr_word_t   mtvec,
    output csr_word_t   mscratch,
    output csr_word_t   mepc,
    output csr_word_t   mcause,
    output csr_word_t   mtval
);

    // Per-register instruction write hits
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    assign wr_mstatus  = csr_wr_en && (csr_addr == CSR_MSTATUS);
    assign wr_mie      = csr_wr_en && (csr_addr == CSR_MIE);
    assign wr_mtvec    = csr_wr_en && (csr_addr == CSR_MTVEC);
    assign wr_mscratch = csr_wr_en && (csr_addr == CSR_MSCRATCH);
    assign wr_mepc     = csr_wr_en && (csr_addr == CSR_MEPC);
    assign wr_mcause   = csr_wr_en && (csr_addr == CSR_MCAUSE);
    assign wr_mtval    = csr_wr_en && (csr_addr == CSR_MTVAL);

    ////////////////////
    // Trap setup
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= `CSR_RESET_WORD;
            mie      <= `CSR_RESET_WORD;
            mtvec    <= `CSR_RESET_WORD;
        end else begin
            // Only MPP, MPIE and MIE hold a value, WPRI fields read zero
            if (ctrl_mstatus_wr) begin
                mstatus <= ctrl_mstatus & `CSR_MSTATUS_MASK;
            end else if (wr_mstatus) begin
                mstatus <= csr_wdata & `CSR_MSTATUS_MASK;
            end
            if (wr_mie) begin
                mie <= csr_wdata;
            end
            // Base and mode kept as written
            if (wr_mtvec) begin
                mtvec <= csr_wdata;
            end
        end
    end

    ////////////////////
    // Trap handling
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mscratch <= `CSR_RESET_WORD;
            mepc     <= `CSR_RESET_WORD;
            mcause   <= `CSR_RESET_WORD;
            mtval    <= `CSR_RESET_WORD;
        end else begin
            if (wr_mscratch) begin
                mscratch <= csr_wdata;
            end
            // IALIGN=32, low two bits tied to zero
            if (ctrl_mepc_wr) begin
                mepc <= {ctrl_mepc[`CSR_XLEN-1:2], 2'b00};
            end else if (wr_mepc) begin
                mepc <= {csr_wdata[`CSR_XLEN-1:2], 2'b00};
            end
            if (ctrl_mcause_wr) begin
                mcause <= ctrl_mcause;
            end else if (wr_mcause) begin
                mcause <= csr_wdata;
            end
            if (ctrl_mtval_wr) begin
                mtval <= ctrl_mtval;
            end else if (wr_mtval) begin
                mtval <= csr_wdata;
            end
        end
    end

endmodule

`default_nettype wire

/* design/regs/csr_irq.sv */
// Interrupt pin synchronizers and the mip register
// A pin reaches its pending bit after the sync depth plus one edge

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_irq
    import csr_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    // Asynchronous pins
    input  wire         ext_irq,
    input  wire         sw_irq,
    input  wire         timer_irq,
    // Global and individual enables
    input  wire         mstatus_mie,
    input  csr_word_t   mie,
    // Instruction write port
    input  wire         csr_wr_en,
    input  csr_addr_t   csr_addr,
    input  csr_word_t   csr_wdata,
    output csr_word_t   mip
);

    // Pin order in the synchronizer vector
    localparam int IRQ_SW    = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    logic [2:0] irq_pins;
    logic [2:0] irq_sync;

    assign irq_pins = {ext_irq, timer_irq, sw_irq};

    ////////////////////
    // Synchronizers
    ////////////////////

    for (genvar i = 0; i < 3; i++) begin : g_sync
        logic [`CSR_SYNC_DEPTH-1:0] sync_q;

        always_ff @(posedge aclk or negedge aresetn) begin
            if (!aresetn) begin
                sync_q <= '0;
            end else begin
                sync_q <= {sync_q[`CSR_SYNC_DEPTH-2:0], irq_pins[i]};
            end
        end

        // Last stage feeds the pending logic
        assign irq_sync[i] = sync_q[`CSR_SYNC_DEPTH-1];
    end

    ////////////////////
    // Pending register
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= `CSR_RESET_WORD;
        end else if (|irq_sync) begin
            // Pins own the pending bits, other mip bits unchanged
            mip[`CSR_MEIP_BIT] <= mstatus_mie & mie[`CSR_MEIP_BIT] & irq_sync[IRQ_EXT];
            mip[`CSR_MTIP_BIT] <= mstatus_mie & mie[`CSR_MTIP_BIT] & irq_sync[IRQ_TIMER];
            mip[`CSR_MSIP_BIT] <= mstatus_mie & mie[`CSR_MSIP_BIT] & irq_sync[IRQ_SW];
        end else if (csr_wr_en && (csr_addr == CSR_MIP)) begin
            // Software write when no pin is active
            mip <= csr_wdata;
        end
    end

endmodule

`default_nettype wire

/* design/csr_unit.sv */
// Machine-mode CSR unit of the RV32I core, one CSR instruction per cycle
// Old value goes back to the register file one cycle after valid

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_unit
    import csr_pkg::*;
(
    input  wire                     aclk,
    input  wire                     aresetn,
    // Instruction in, no back-pressure
    input  wire                     valid,
    input  wire  [31:0]             instbus,
    // Register file read and write-back
    output reg_idx_t                rs1_addr,
    input  csr_word_t               rs1_val,
    output logic                    rd_wr_en,
    output reg_idx_t                rd_wr_addr,
    output csr_word_t               rd_wr_val,
    // Trap-entry writes from the control unit
    input  wire                     ctrl_mstatus_wr,
    input  csr_word_t               ctrl_mstatus,
    input  wire                     ctrl_mepc_wr,
    input  csr_word_t               ctrl_mepc,
    input  wire                     ctrl_mcause_wr,
    input  csr_word_t               ctrl_mcause,
    input  wire                     ctrl_mtval_wr,
    input  csr_word_t               ctrl_mtval,
    input  wire  [`CSR_CNT_W-1:0]   instret,
    // Asynchronous interrupt pins
    input  wire                     ext_irq,
    input  wire                     sw_irq,
    input  wire                     timer_irq,
    // Exported state
    output csr_word_t               mtvec,
    output csr_word_t               mepc,
    output csr_word_t               mstatus,
    output logic                    meip,
    output logic                    mtip,
    output logic                    msip
);

    // Write path shared by all storage blocks
    logic       csr_wr_en;
    csr_addr_t  csr_addr;
    csr_word_t  csr_wdata;
    csr_word_t  old_val;

    // Registers only read back through the selector
    csr_word_t  mie;
    csr_word_t  mscratch;
    csr_word_t  mcause;
    csr_word_t  mtval;
    csr_word_t  mip;

    csr_access_ctrl i_access_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .instbus    (instbus),
        .rs1_val    (rs1_val),
        .old_val    (old_val),
        .rs1_addr   (rs1_addr),
        .csr_addr   (csr_addr),
        .csr_wr_en  (csr_wr_en),
        .csr_wdata  (csr_wdata),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val)
    );

    csr_read_select i_read_select (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .csr_addr (csr_addr),
        .instret  (instret),
        .mstatus  (mstatus),
        .mie      (mie),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .mip      (mip),
        .old_val  (old_val)
    );

    csr_machine_regs i_machine_regs (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .csr_wr_en       (csr_wr_en),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .ctrl_mtval_wr   (ctrl_mtval_wr),
        .ctrl_mtval      (ctrl_mtval),
        .mstatus         (mstatus),
        .mie             (mie),
        .mtvec           (mtvec),
        .mscratch        (mscratch),
        .mepc            (mepc),
        .mcause          (mcause),
        .mtval           (mtval)
    );

    csr_irq i_irq (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .ext_irq     (ext_irq),
        .sw_irq      (sw_irq),
        .timer_irq   (timer_irq),
        .mstatus_mie (mstatus[`CSR_MSTATUS_MIE_BIT]),
        .mie         (mie),
        .csr_wr_en   (csr_wr_en),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .mip         (mip)
    );

    // Pending flags for the core's interrupt logic
    assign meip = mip[`CSR_MEIP_BIT];
    assign mtip = mip[`CSR_MTIP_BIT];
    assign msip = mip[`CSR_MSIP_BIT];

endmodule

`default_nettype wire

/* test/tb_csr_ref.svh */
// Reference model of the machine CSRs, included inside the testbench module
// Holds the expected CSR contents and the Zicsr update rules

`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

// Expected contents, indexed by the 12-bit CSR address
csr_word_t model_csr [0:4095];

// Only MPP [12:11], MPIE [7] and MIE [3] keep a value
function automatic csr_word_t mstatus_legal(input csr_word_t v);
    csr_word_t keep;
    keep = (32'h3 << 11) | (32'h1 << 7) | (32'h1 << 3);
    return v & keep;
endfunction

// Word-aligned return address
function automatic csr_word_t mepc_align(input csr_word_t v);
    return {v[31:2], 2'b00};
endfunction

// Write rule per funct3 and source field
function automatic logic op_writes(input logic [2:0] f3, input reg_idx_t src);
    case (f3)
        CSRRW, CSRRWI:                 return 1'b1;
        CSRRS, CSRRSI, CSRRC, CSRRCI:  return src != 5'd0;
        default:                       return 1'b0;
    endcase
endfunction

function automatic csr_word_t next_csr_value(input logic [2:0] f3, input csr_word_t old,
                                             input csr_word_t src);
    case (f3)
        CSRRW, CSRRWI: return src;
        CSRRS, CSRRSI: return old | src;
        // Clear the bits set in the source
        CSRRC, CSRRCI: return old & ~src;
        default:       return old;
    endcase
endfunction

// Store with the legal-value rules of the target
function automatic void store_csr(input csr_addr_t addr, input csr_word_t v);
    case (addr)
        CSR_MSTATUS: model_csr[addr] = mstatus_legal(v);
        CSR_MEPC:    model_csr[addr] = mepc_align(v);
        default:     model_csr[addr] = v;
    endcase
endfunction

// Old value seen by an instruction, cnt is the edge count in its cycle
function automatic csr_word_t expected_read(input csr_addr_t addr, input logic [63:0] cnt,
                                            input logic [63:0] ir);
    case (addr)
        // MXL=1 and the I extension, letter I is bit 8
        CSR_MISA:                return (32'h1 << 30) | (32'h1 << ("I" - "A"));
        CSR_MHARTID:             return 32'h0;
        CSR_CYCLE, CSR_TIME:     return cnt[31:0];
        CSR_CYCLEH, CSR_TIMEH:   return cnt[63:32];
        CSR_INSTRET:             return ir[31:0];
        CSR_INSTRETH:            return ir[63:32];
        default:                 return model_csr[addr];
    endcase
endfunction

`endif

/* test/tb_csr_unit.sv */
// Testbench of the machine-mode CSR unit
// Random Zicsr traffic, trap-entry writes, counter reads and interrupt pins

`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module tb_csr_unit
    import csr_pkg::*;
();

    // Run length for the cycle limit
    localparam int RAND_OPS    = 400;
    localparam int READ_OPS    = 7;
    localparam int TRAP_OPS    = 8;
    localparam int CNT_OPS     = 20;
    localparam int IRQ_WAIT    = 6 * (2 * `CSR_SYNC_DEPTH + 7) + 10;
    localparam int MARGIN      = 100;
    localparam int CYCLE_LIMIT = 3 + RAND_OPS + READ_OPS + TRAP_OPS + CNT_OPS + IRQ_WAIT + MARGIN;

    logic        aclk;
    logic        aresetn;
    logic        valid;
    logic [31:0] instbus;
    reg_idx_t    rs1_addr;
    csr_word_t   rs1_val;
    logic        rd_wr_en;
    reg_idx_t    rd_wr_addr;
    csr_word_t   rd_wr_val;
    logic        ctrl_mstatus_wr;
    csr_word_t   ctrl_mstatus;
    logic        ctrl_mepc_wr;
    csr_word_t   ctrl_mepc;
    logic        ctrl_mcause_wr;
    csr_word_t   ctrl_mcause;
    logic        ctrl_mtval_wr;
    csr_word_t   ctrl_mtval;
    logic [63:0] instret;
    logic        ext_irq;
    logic        sw_irq;
    logic        timer_irq;
    csr_word_t   mtvec;
    csr_word_t   mepc;
    csr_word_t   mstatus;
    logic        meip;
    logic        mtip;
    logic        msip;

    // Expected write-back and exported ports per instruction
    typedef struct packed {
        reg_idx_t  rd;
        csr_word_t old_val;
        csr_word_t mstatus;
        csr_word_t mepc;
        csr_word_t mtvec;
    } wb_exp_t;

    wb_exp_t     exp_q [$];
    csr_word_t   regfile [0:31];
    logic [63:0] instret_ref;
    logic [63:0] run_edges;
    logic [31:0] lfsr_state;
    int unsigned cycle_cnt = 0;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;

    `include "tb_csr_ref.svh"

    csr_unit i_dut (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .valid           (valid),
        .instbus         (instbus),
        .rs1_addr        (rs1_addr),
        .rs1_val         (rs1_val),
        .rd_wr_en        (rd_wr_en),
        .rd_wr_addr      (rd_wr_addr),
        .rd_wr_val       (rd_wr_val),
        .ctrl_mstatus_wr (ctrl_mstatus_wr),
        .ctrl_mstatus    (ctrl_mstatus),
        .ctrl_mepc_wr    (ctrl_mepc_wr),
        .ctrl_mepc       (ctrl_mepc),
        .ctrl_mcause_wr  (ctrl_mcause_wr),
        .ctrl_mcause     (ctrl_mcause),
        .ctrl_mtval_wr   (ctrl_mtval_wr),
        .ctrl_mtval      (ctrl_mtval),
        .instret         (instret),
        .ext_irq         (ext_irq),
        .sw_irq          (sw_irq),
        .timer_irq       (timer_irq),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus         (mstatus),
        .meip            (meip),
        .mtip            (mtip),
        .msip            (msip)
    );

    // Register file answers rs1 in the same cycle
    assign rs1_val = regfile[rs1_addr];

    initial aclk = 1'b0;
    always #50 aclk = ~aclk;

    // Edges since reset release as time base of cycle and time
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            run_edges <= '0;
        end else begin
            run_edges <= run_edges + 64'd1;
        end
    end

    always @(posedge aclk) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // CSRs hit by the random phase
    function automatic csr_addr_t target_addr(input logic [2:0] idx);
        case (idx)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MIE;
            3'd2:    return CSR_MTVEC;
            3'd3:    return CSR_MEPC;
            3'd4:    return CSR_MCAUSE;
            3'd5:    return CSR_MTVAL;
            default: return CSR_MSCRATCH;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input csr_word_t got, input csr_word_t exp);
        mismatch_cnt++;
        $display("Mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    endtask

    // One instruction with an optional trap-entry write to the same CSR
    task automatic issue(input logic [2:0] f3, input csr_addr_t addr, input reg_idx_t src,
                         input reg_idx_t rd, input logic trap, input csr_word_t trap_val);
        csr_word_t old;
        csr_word_t opnd;
        wb_exp_t   e;
        @(posedge aclk);
        valid           <= 1'b1;
        instbus         <= {addr, src, f3, rd, 7'b1110011};
        ctrl_mstatus_wr <= trap && (addr == CSR_MSTATUS);
        ctrl_mepc_wr    <= trap && (addr == CSR_MEPC);
        ctrl_mcause_wr  <= trap && (addr == CSR_MCAUSE);
        ctrl_mtval_wr   <= trap && (addr == CSR_MTVAL);
        ctrl_mstatus    <= trap_val;
        ctrl_mepc       <= trap_val;
        ctrl_mcause     <= trap_val;
        ctrl_mtval      <= trap_val;
        // Counter during the valid cycle is one past the edges seen so far
        old  = expected_read(addr, run_edges + 64'd1, instret_ref);
        opnd = f3[2] ? {{(`CSR_XLEN-5){1'b0}}, src} : regfile[src];
        if (op_writes(f3, src)) begin
            store_csr(addr, next_csr_value(f3, old, opnd));
        end
        // Trap entry lands last and wins
        if (trap) begin
            store_csr(addr, trap_val);
        end
        e.rd      = rd;
        e.old_val = old;
        e.mstatus = model_csr[CSR_MSTATUS];
        e.mepc    = model_csr[CSR_MEPC];
        e.mtvec   = model_csr[CSR_MTVEC];
        exp_q.push_back(e);
        // Register file query in the middle of the valid cycle
        @(negedge aclk);
        assert (rs1_addr === src) else
            report_mismatch("rs1_addr", rs1_addr, src);
    endtask

    task automatic idle();
        @(posedge aclk);
        valid           <= 1'b0;
        ctrl_mstatus_wr <= 1'b0;
        ctrl_mepc_wr    <= 1'b0;
        ctrl_mcause_wr  <= 1'b0;
        ctrl_mtval_wr   <= 1'b0;
    endtask

    function automatic logic pending_of(input int pin);
        case (pin)
            0:       return msip;
            1:       return mtip;
            default: return meip;
        endcase
    endfunction

    task automatic drive_pin(input int pin, input logic lvl);
        case (pin)
            0:       sw_irq <= lvl;
            1:       timer_irq <= lvl;
            default: ext_irq <= lvl;
        endcase
    endtask

    // Hold one pin high and watch its pending output
    task automatic hold_irq(input int pin, input logic expect_rise);
        int first_high;
        first_high = -1;
        @(posedge aclk);
        drive_pin(pin, 1'b1);
        // n edges have passed since the drive edge
        for (int n = 0; n <= `CSR_SYNC_DEPTH + 2; n++) begin
            @(negedge aclk);
            if (pending_of(pin) === 1'b1 && first_high < 0) begin
                first_high = n;
            end
        end
        if (expect_rise) begin
            assert (first_high >= 0 && first_high <= `CSR_SYNC_DEPTH + 1) else begin
                fail_cnt++;
                $display("Pending output of pin %0d did not rise in time at %0t", pin, $time);
            end
        end else begin
            assert (first_high < 0) else
                report_mismatch($sformatf("pending of pin %0d with enables clear", pin), 1, 0);
        end
        @(posedge aclk);
        drive_pin(pin, 1'b0);
        repeat (`CSR_SYNC_DEPTH + 2) @(posedge aclk);
    endtask

    ////////////////////
    // Compare process
    ////////////////////

    always @(negedge aclk) begin : compare_wb
        wb_exp_t e;
        if (aresetn && rd_wr_en === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                fail_cnt++;
                $display("Write-back at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (rd_wr_addr === e.rd) else
                    report_mismatch("rd_wr_addr", rd_wr_addr, e.rd);
                assert (rd_wr_val === e.old_val) else
                    report_mismatch("rd_wr_val", rd_wr_val, e.old_val);
                assert (mstatus === e.mstatus) else
                    report_mismatch("mstatus port", mstatus, e.mstatus);
                assert (mepc === e.mepc) else
                    report_mismatch("mepc port", mepc, e.mepc);
                assert (mtvec === e.mtvec) else
                    report_mismatch("mtvec port", mtvec, e.mtvec);
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        logic [2:0] f3;
        reg_idx_t   src;
        aresetn         = 1'b0;
        valid           = 1'b0;
        instbus         = '0;
        ctrl_mstatus_wr = 1'b0;
        ctrl_mstatus    = '0;
        ctrl_mepc_wr    = 1'b0;
        ctrl_mepc       = '0;
        ctrl_mcause_wr  = 1'b0;
        ctrl_mcause     = '0;
        ctrl_mtval_wr   = 1'b0;
        ctrl_mtval      = '0;
        instret         = '0;
        instret_ref     = '0;
        ext_irq         = 1'b0;
        sw_irq          = 1'b0;
        timer_irq       = 1'b0;
        lfsr_state      = 32'hb1cd_5ae3;
        for (int a = 0; a < 4096; a++) begin
            model_csr[a] = '0;
        end
        regfile[0] = '0;
        for (int r = 1; r < 31; r++) begin
            regfile[r] = rand_bits(32);
        end
        // x31 holds the MEIE, MTIE and MSIE pattern
        regfile[31] = (32'h1 << 11) | (32'h1 << 7) | (32'h1 << 3);

        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        // Random traffic with about one in four zero sources
        for (int i = 0; i < RAND_OPS; i++) begin
            f3  = rand_bits(3);
            src = (rand_bits(2) == 0) ? 5'd0 : rand_bits(5);
            issue(f3, target_addr(rand_bits(3)), src, rand_bits(5), 1'b0, '0);
        end
        for (int t = 0; t < READ_OPS; t++) begin
            issue(CSRRS, target_addr(t), 5'd0, 5'd1, 1'b0, '0);
        end

        // Trap entry against an instruction write and a read back
        issue(CSRRW, CSR_MSTATUS, 5'd3, 5'd2, 1'b1, rand_bits(32));
        issue(CSRRS, CSR_MSTATUS, 5'd0, 5'd2, 1'b0, '0);
        issue(CSRRW, CSR_MEPC, 5'd4, 5'd3, 1'b1, rand_bits(32));
        issue(CSRRS, CSR_MEPC, 5'd0, 5'd3, 1'b0, '0);
        issue(CSRRWI, CSR_MCAUSE, 5'd9, 5'd4, 1'b1, rand_bits(32));
        issue(CSRRS, CSR_MCAUSE, 5'd0, 5'd4, 1'b0, '0);
        issue(CSRRSI, CSR_MTVAL, 5'd17, 5'd5, 1'b1, rand_bits(32));
        issue(CSRRS, CSR_MTVAL, 5'd0, 5'd5, 1'b0, '0);
        idle();

        // Counters and constants
        instret_ref = {rand_bits(32), rand_bits(32)};
        instret     <= instret_ref;
        issue(CSRRS, CSR_CYCLE, 5'd0, 5'd6, 1'b0, '0);
        issue(CSRRS, CSR_TIME, 5'd0, 5'd6, 1'b0, '0);
        idle();
        repeat (3) @(posedge aclk);
        issue(CSRRS, CSR_CYCLE, 5'd0, 5'd7, 1'b0, '0);
        issue(CSRRC, CSR_TIME, 5'd0, 5'd7, 1'b0, '0);
        issue(CSRRS, CSR_CYCLEH, 5'd0, 5'd8, 1'b0, '0);
        issue(CSRRS, CSR_TIMEH, 5'd0, 5'd8, 1'b0, '0);
        issue(CSRRS, CSR_INSTRET, 5'd0, 5'd9, 1'b0, '0);
        issue(CSRRS, CSR_INSTRETH, 5'd0, 5'd9, 1'b0, '0);
        issue(CSRRS, CSR_MISA, 5'd0, 5'd10, 1'b0, '0);
        issue(CSRRS, CSR_MHARTID, 5'd0, 5'd10, 1'b0, '0);
        idle();

        // Interrupts with both enables clear
        issue(CSRRCI, CSR_MSTATUS, 5'd8, 5'd0, 1'b0, '0);
        issue(CSRRW, CSR_MIE, 5'd0, 5'd0, 1'b0, '0);
        idle();
        for (int p = 0; p < 3; p++) begin
            hold_irq(p, 1'b0);
        end

        // Global MIE and all three individual enables set
        issue(CSRRW, CSR_MIE, 5'd31, 5'd0, 1'b0, '0);
        issue(CSRRSI, CSR_MSTATUS, 5'd8, 5'd0, 1'b0, '0);
        idle();
        for (int p = 0; p < 3; p++) begin
            hold_irq(p, 1'b1);
        end

        // Last write-back lands one cycle after its instruction
        repeat (2) @(posedge aclk);
        assert (exp_q.size() == 0) else begin
            fail_cnt++;
            $display("%0d write-backs never arrived", exp_q.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
+incdir+test
common/csr_pkg.sv
design/access/csr_access_ctrl.sv
design/access/csr_read_select.sv
design/regs/csr_machine_regs.sv
design/regs/csr_irq.sv
design/csr_unit.sv
test/tb_csr_unit.sv
